// File: Bender.yml
package:
  name: control_unit

sources:
  - include_dirs:
      - .
    files:
      - controlPkg.sv
      - instrDecoder.sv
      - controlSequencer.sv
      - controlWordGen.sv
      - controlUnit.sv
  - target: test
    include_dirs:
      - .
    files:
      - controlChecker.sv
      - tb_controlUnit.sv

// File: build.f
+incdir+.
controlPkg.sv
instrDecoder.sv
controlSequencer.sv
controlWordGen.sv
controlUnit.sv
controlChecker.sv
tb_controlUnit.sv

// File: controlChecker.sv
`timescale 1ns/1ns
`include "control_cfg.svh"

module controlChecker (
  input logic                 clk,
  input logic                 reset,
  input logic [`OPCODE_W-1:0] opcode,
  input logic [`FUNCT_W-1:0]  funct,
  input logic                 overflow,
  input controlPkg::ctrlWordT ctrl,
  input logic                 resetOut
);

  controlPkg::stateT mState = controlPkg::StReset;
  controlPkg::opT    mOp = controlPkg::OpAdd;
  int                fetchCnt = 0;
  logic              started = 1'b0;
  int                checkCount = 0;
  int                errorCount = 0;
  int                exceptCount = 0;

  // Operation named by the opcode and funct fields
  function automatic controlPkg::opT classify(input logic [5:0] opc, input logic [5:0] fn);
    controlPkg::opT result;
    result = controlPkg::OpIllegal;
    if (opc == `OP_ADDI) result = controlPkg::OpAddi;
    else if (opc == `OP_J) result = controlPkg::OpJ;
    else if (opc == `OP_JAL) result = controlPkg::OpJal;
    else if (opc == `OP_R) begin
      if (fn == `FN_ADD) result = controlPkg::OpAdd;
      else if (fn == `FN_SUB) result = controlPkg::OpSub;
      else if (fn == `FN_AND) result = controlPkg::OpAnd;
      else if (fn == `FN_SLT) result = controlPkg::OpSlt;
      else if (fn == `FN_JR) result = controlPkg::OpJr;
      else if (fn == `FN_XCHG) result = controlPkg::OpXchg;
    end
    return result;
  endfunction

  // Reference control word for one step of the sequence
  function automatic controlPkg::ctrlWordT expectedWord(input controlPkg::stateT st,
                                                       input controlPkg::opT o);
    controlPkg::ctrlWordT w;
    w = '0;
    if (st == controlPkg::StFetch) begin
      w.iorD = `IORD_PC;
    end else if (st == controlPkg::StPcInc) begin
      w.pcWrite = 1'b1;
      w.aluSrcB = `SRCB_FOUR;
      w.aluSel = `ALU_ADD;
      w.pcSource = `PCSRC_ALU;
    end else if (st == controlPkg::StIrLoad) begin
      w.irWrite = 1'b1;
    end else if (st == controlPkg::StDecode) begin
      w.aWrite = 1'b1;
      w.bWrite = 1'b1;
    end else if (st == controlPkg::StXchg2) begin
      w.regWrite = 1'b1;
      w.regDst = `DST_RS;
      w.memToReg = `WB_B;
    end else if (st == controlPkg::StExcept) begin
      w.epcWrite = 1'b1;
      w.pcWrite = 1'b1;
      w.pcSource = `PCSRC_VECTOR;
      w.cause = (o == controlPkg::OpIllegal) ? `CAUSE_ILLEGAL : `CAUSE_OVF;
    end else if (st == controlPkg::StExec) begin
      if (o == controlPkg::OpAdd || o == controlPkg::OpSub || o == controlPkg::OpAnd ||
          o == controlPkg::OpSlt || o == controlPkg::OpAddi) begin
        w.regWrite = 1'b1;
        w.aluSrcA = 1'b1;
        w.memToReg = `WB_ALU;
        w.aluSrcB = (o == controlPkg::OpAddi) ? `SRCB_IMM : `SRCB_REG;
        w.regDst = (o == controlPkg::OpAddi) ? `DST_RT : `DST_RD;
        if (o == controlPkg::OpSub) w.aluSel = `ALU_SUB;
        else if (o == controlPkg::OpAnd) w.aluSel = `ALU_AND;
        else if (o == controlPkg::OpSlt) w.aluSel = `ALU_SLT;
        else w.aluSel = `ALU_ADD;
      end else if (o == controlPkg::OpJr) begin
        w.pcWrite = 1'b1;
        w.pcSource = `PCSRC_A;
      end else if (o == controlPkg::OpJ || o == controlPkg::OpJal) begin
        w.pcWrite = 1'b1;
        w.pcSource = `PCSRC_JUMP;
        if (o == controlPkg::OpJal) begin
          w.regWrite = 1'b1;
          w.regDst = `DST_RA;
          w.memToReg = `WB_PC;
        end
      end else if (o == controlPkg::OpXchg) begin
        w.regWrite = 1'b1;
        w.regDst = `DST_RT;
        w.memToReg = `WB_A;
      end
    end
    return w;
  endfunction

  task automatic checkField(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("** Error at %0t ns: %s is %0h, expected %0h in %s/%s", $time, name, got,
               expected, mState.name(), mOp.name());
    end
  endtask

  task automatic compareOutputs();
    controlPkg::ctrlWordT e;
    e = expectedWord(mState, mOp);
    checkField("resetOut", resetOut, mState == controlPkg::StReset);
    checkField("pcWrite", ctrl.pcWrite, e.pcWrite);
    checkField("aWrite", ctrl.aWrite, e.aWrite);
    checkField("bWrite", ctrl.bWrite, e.bWrite);
    checkField("epcWrite", ctrl.epcWrite, e.epcWrite);
    checkField("irWrite", ctrl.irWrite, e.irWrite);
    checkField("regWrite", ctrl.regWrite, e.regWrite);
    checkField("aluSel", ctrl.aluSel, e.aluSel);
    checkField("aluSrcA", ctrl.aluSrcA, e.aluSrcA);
    checkField("aluSrcB", ctrl.aluSrcB, e.aluSrcB);
    checkField("regDst", ctrl.regDst, e.regDst);
    checkField("memToReg", ctrl.memToReg, e.memToReg);
    checkField("iorD", ctrl.iorD, e.iorD);
    checkField("pcSource", ctrl.pcSource, e.pcSource);
    checkField("cause", ctrl.cause, e.cause);
  endtask

  // Mid-cycle sampling, inputs here are what the DUT sees at the next edge
  always @(negedge clk) begin
    if (started) begin
      compareOutputs();
    end
    if (reset) begin
      started = 1'b1;
      mState = controlPkg::StReset;
      fetchCnt = 0;
    end else begin
      case (mState)
        controlPkg::StReset: begin
          mState = controlPkg::StFetch;
          fetchCnt = 0;
        end
        controlPkg::StFetch: begin
          fetchCnt++;
          if (fetchCnt == `FETCH_WAIT) begin
            mState = controlPkg::StPcInc;
            fetchCnt = 0;
          end
        end
        controlPkg::StPcInc: mState = controlPkg::StIrLoad;
        controlPkg::StIrLoad: mState = controlPkg::StDecode;
        controlPkg::StDecode: begin
          mOp = classify(opcode, funct);
          mState = (mOp == controlPkg::OpIllegal) ? controlPkg::StExcept : controlPkg::StExec;
        end
        controlPkg::StExec: begin
          if (overflow && (mOp == controlPkg::OpAdd || mOp == controlPkg::OpSub ||
                           mOp == controlPkg::OpAddi)) begin
            mState = controlPkg::StExcept;
          end else if (mOp == controlPkg::OpXchg) begin
            mState = controlPkg::StXchg2;
          end else begin
            mState = controlPkg::StFetch;
          end
        end
        controlPkg::StExcept: begin
          exceptCount++;
          mState = controlPkg::StFetch;
        end
        default: mState = controlPkg::StFetch;
      endcase
    end
  end

endmodule

// File: controlPkg.sv
package controlPkg;

  // Operations the unit knows how to execute
  typedef enum logic [3:0] {
    OpAdd,
    OpSub,
    OpAnd,
    OpSlt,
    OpJr,
    OpXchg,
    OpAddi,
    OpJ,
    OpJal,
    OpIllegal
  } opT;

  // Sequencer states
  typedef enum logic [3:0] {
    StReset,
    StFetch,
    StPcInc,
    StIrLoad,
    StDecode,
    StExec,
    StXchg2,
    StExcept
  } stateT;

  // Datapath control word, strobes first
  typedef struct packed {
    logic       pcWrite;
    logic       aWrite;
    logic       bWrite;
    logic       epcWrite;
    logic       irWrite;
    logic       regWrite;
    // ALU operation and operands
    logic [2:0] aluSel;
    // 0 selects PC, 1 selects register A
    logic       aluSrcA;
    logic [1:0] aluSrcB;
    // Register file write port
    logic [2:0] regDst;
    logic [3:0] memToReg;
    // Memory address and next PC
    logic [2:0] iorD;
    logic [1:0] pcSource;
    logic       cause;
  } ctrlWordT;

endpackage

// File: controlSequencer.sv
`timescale 1ns/1ns
`include "control_cfg.svh"

module controlSequencer (
  input  logic                  clk,
  input  logic                  reset,
  input  controlPkg::opT        op,
  input  logic                  overflow,
  output controlPkg::stateT     state,
  output controlPkg::opT        curOp,
  output logic                  resetOut
);

  localparam int unsigned WaitW = $clog2(`FETCH_WAIT + 1);
  localparam logic [WaitW-1:0] LastWait = WaitW'(`FETCH_WAIT - 1);

  logic [WaitW-1:0] waitCnt;
  logic             trapsOverflow;

  // Only the signed arithmetic ops raise overflow
  assign trapsOverflow = (curOp == controlPkg::OpAdd) ||
                         (curOp == controlPkg::OpSub) ||
                         (curOp == controlPkg::OpAddi);

  assign resetOut = (state == controlPkg::StReset);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= controlPkg::StReset;
      curOp   <= controlPkg::OpAdd;
      waitCnt <= '0;
    end else begin
      case (state)
        controlPkg::StReset: begin
          state   <= controlPkg::StFetch;
          waitCnt <= '0;
        end
        controlPkg::StFetch: begin
          // Hold until instruction memory has answered
          if (waitCnt == LastWait) begin
            state   <= controlPkg::StPcInc;
            waitCnt <= '0;
          end else begin
            waitCnt <= waitCnt + 1'b1;
          end
        end
        controlPkg::StPcInc: begin
          state <= controlPkg::StIrLoad;
        end
        controlPkg::StIrLoad: begin
          state <= controlPkg::StDecode;
        end
        controlPkg::StDecode: begin
          // IR is valid here, so the decoded op is stable
          curOp <= op;
          if (op == controlPkg::OpIllegal) begin
            state <= controlPkg::StExcept;
          end else begin
            state <= controlPkg::StExec;
          end
        end
        controlPkg::StExec: begin
          if (overflow && trapsOverflow) begin
            state <= controlPkg::StExcept;
          end else if (curOp == controlPkg::OpXchg) begin
            state <= controlPkg::StXchg2;
          end else begin
            state <= controlPkg::StFetch;
          end
        end
        controlPkg::StXchg2: begin
          state <= controlPkg::StFetch;
        end
        controlPkg::StExcept: begin
          // curOp still tells illegal apart from overflow
          state <= controlPkg::StFetch;
        end
        default: begin
          state <= controlPkg::StReset;
        end
      endcase
    end
  end

endmodule

// File: controlUnit.sv
`timescale 1ns/1ns
`include "control_cfg.svh"

module controlUnit (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [`OPCODE_W-1:0] opcode,
  input  logic [`FUNCT_W-1:0]  funct,
  input  logic                 overflow,
  output controlPkg::ctrlWordT ctrl,
  output logic                 resetOut
);

  controlPkg::opT    op;
  controlPkg::opT    curOp;
  controlPkg::stateT state;

  instrDecoder decoder (
    .opcode (opcode),
    .funct  (funct),
    .op     (op)
  );

  controlSequencer sequencer (
    .clk      (clk),
    .reset    (reset),
    .op       (op),
    .overflow (overflow),
    .state    (state),
    .curOp    (curOp),
    .resetOut (resetOut)
  );

  controlWordGen wordGen (
    .state (state),
    .curOp (curOp),
    .ctrl  (ctrl)
  );

endmodule

// File: controlWordGen.sv
`timescale 1ns/1ns
`include "control_cfg.svh"

module controlWordGen (
  input  controlPkg::stateT    state,
  input  controlPkg::opT       curOp,
  output controlPkg::ctrlWordT ctrl
);

  always_comb begin
    ctrl = '0;
    case (state)
      controlPkg::StFetch: begin
        ctrl.iorD = `IORD_PC;
      end
      controlPkg::StPcInc: begin
        // PC + 4 through the ALU
        ctrl.pcWrite  = 1'b1;
        ctrl.aluSrcA  = 1'b0;
        ctrl.aluSrcB  = `SRCB_FOUR;
        ctrl.aluSel   = `ALU_ADD;
        ctrl.pcSource = `PCSRC_ALU;
      end
      controlPkg::StIrLoad: begin
        ctrl.irWrite = 1'b1;
      end
      controlPkg::StDecode: begin
        ctrl.aWrite = 1'b1;
        ctrl.bWrite = 1'b1;
      end
      controlPkg::StExec: begin
        case (curOp)
          controlPkg::OpAdd,
          controlPkg::OpSub,
          controlPkg::OpAnd,
          controlPkg::OpSlt: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrcA  = 1'b1;
            ctrl.aluSrcB  = `SRCB_REG;
            ctrl.regDst   = `DST_RD;
            ctrl.memToReg = `WB_ALU;
            case (curOp)
              controlPkg::OpSub: ctrl.aluSel = `ALU_SUB;
              controlPkg::OpAnd: ctrl.aluSel = `ALU_AND;
              controlPkg::OpSlt: ctrl.aluSel = `ALU_SLT;
              default: ctrl.aluSel = `ALU_ADD;
            endcase
          end
          controlPkg::OpAddi: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSel   = `ALU_ADD;
            ctrl.aluSrcA  = 1'b1;
            ctrl.aluSrcB  = `SRCB_IMM;
            ctrl.regDst   = `DST_RT;
            ctrl.memToReg = `WB_ALU;
          end
          controlPkg::OpJr: begin
            ctrl.pcWrite  = 1'b1;
            ctrl.pcSource = `PCSRC_A;
          end
          controlPkg::OpJ: begin
            ctrl.pcWrite  = 1'b1;
            ctrl.pcSource = `PCSRC_JUMP;
          end
          controlPkg::OpJal: begin
            // Return address goes to $ra while PC jumps
            ctrl.pcWrite  = 1'b1;
            ctrl.pcSource = `PCSRC_JUMP;
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = `DST_RA;
            ctrl.memToReg = `WB_PC;
          end
          controlPkg::OpXchg: begin
            // First half, old rs value into rt
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = `DST_RT;
            ctrl.memToReg = `WB_A;
          end
          default: begin
            ctrl = '0;
          end
        endcase
      end
      controlPkg::StXchg2: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = `DST_RS;
        ctrl.memToReg = `WB_B;
      end
      controlPkg::StExcept: begin
        ctrl.epcWrite = 1'b1;
        ctrl.pcWrite  = 1'b1;
        ctrl.pcSource = `PCSRC_VECTOR;
        if (curOp == controlPkg::OpIllegal) begin
          ctrl.cause = `CAUSE_ILLEGAL;
        end else begin
          ctrl.cause = `CAUSE_OVF;
        end
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

// File: control_cfg.svh
`ifndef CONTROL_CFG_SVH
`define CONTROL_CFG_SVH

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6

// Instruction memory latency seen by fetch
`define FETCH_WAIT 2

// Opcodes
`define OP_R      6'b000000
`define OP_ADDI   6'b001000
`define OP_J      6'b000010
`define OP_JAL    6'b000011
`define OP_XCHG_R 6'b000000

// R-type functs
`define FN_ADD  6'b100000
`define FN_SUB  6'b100010
`define FN_AND  6'b100100
`define FN_SLT  6'b101010
`define FN_JR   6'b001000
`define FN_XCHG 6'b000101

// ALU operations
`define ALU_ADD 3'b001
`define ALU_SUB 3'b010
`define ALU_AND 3'b011
`define ALU_SLT 3'b111

// ALU B operand
`define SRCB_REG  2'b00
`define SRCB_FOUR 2'b01
`define SRCB_IMM  2'b10

// Register file write address
`define DST_RT 3'b000
`define DST_RD 3'b001
`define DST_RA 3'b010
`define DST_RS 3'b100

// Register file write data
`define WB_ALU 4'b0000
`define WB_PC  4'b1000
`define WB_A   4'b1001
`define WB_B   4'b0111

// Memory address during fetch
`define IORD_PC 3'b011

// Next PC
`define PCSRC_ALU    2'b00
`define PCSRC_JUMP   2'b01
`define PCSRC_A      2'b10
`define PCSRC_VECTOR 2'b11

// Exception cause register value
`define CAUSE_ILLEGAL 1'b0
`define CAUSE_OVF     1'b1

`endif

// File: instrDecoder.sv
`timescale 1ns/1ns
`include "control_cfg.svh"

module instrDecoder (
  input  logic [`OPCODE_W-1:0] opcode,
  input  logic [`FUNCT_W-1:0]  funct,
  output controlPkg::opT       op
);

  always_comb begin
    op = controlPkg::OpIllegal;
    case (opcode)
      `OP_R: begin
        case (funct)
          `FN_ADD: begin
            op = controlPkg::OpAdd;
          end
          `FN_SUB: begin
            op = controlPkg::OpSub;
          end
          `FN_AND: begin
            op = controlPkg::OpAnd;
          end
          `FN_SLT: begin
            op = controlPkg::OpSlt;
          end
          `FN_JR: begin
            op = controlPkg::OpJr;
          end
          `FN_XCHG: begin
            // xchg lives under the R-type opcode
            op = controlPkg::OpXchg;
          end
          default: begin
            op = controlPkg::OpIllegal;
          end
        endcase
      end
      `OP_ADDI: begin
        op = controlPkg::OpAddi;
      end
      `OP_J: begin
        op = controlPkg::OpJ;
      end
      `OP_JAL: begin
        op = controlPkg::OpJal;
      end
      default: begin
        op = controlPkg::OpIllegal;
      end
    endcase
  end

endmodule

// File: tb_controlUnit.sv
`timescale 1ns/1ns
`include "control_cfg.svh"

module tb_controlUnit;

  localparam logic [15:0] Seed = 16'd86;
  localparam int NumInstr = 300;
  localparam int IrTimeout = 64;

  logic                 clk;
  logic                 reset;
  logic [`OPCODE_W-1:0] opcode;
  logic [`FUNCT_W-1:0]  funct;
  logic                 overflow;
  controlPkg::ctrlWordT ctrl;
  logic                 resetOut;
  logic [15:0]          lfsr;
  int                   instrCount;
  int                   timeoutCount;

  controlUnit UUT (
    .clk      (clk),
    .reset    (reset),
    .opcode   (opcode),
    .funct    (funct),
    .overflow (overflow),
    .ctrl     (ctrl),
    .resetOut (resetOut)
  );

  controlChecker monitor (
    .clk      (clk),
    .reset    (reset),
    .opcode   (opcode),
    .funct    (funct),
    .overflow (overflow),
    .ctrl     (ctrl),
    .resetOut (resetOut)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Galois LFSR stepped once per bit
  function automatic logic nextBit();
    logic outBit;
    outBit = lfsr[0];
    lfsr = lfsr >> 1;
    if (outBit) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return outBit;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], nextBit()};
    end
    return v;
  endfunction

  // Steps one cycle and looks for the IR-load word
  task automatic waitForIrLoad(output logic seen);
    int n;
    seen = 1'b0;
    for (n = 0; n < IrTimeout && !seen; n++) begin
      @(posedge clk);
      #1;
      overflow = nextBit();
      if (ctrl.irWrite === 1'b1) begin
        seen = 1'b1;
      end
    end
  endtask

  task automatic driveInstruction();
    logic [5:0] pick;
    @(posedge clk);
    #1;
    overflow = nextBit();
    if (randBits(3) == 0) begin
      opcode = 6'(randBits(6));
      funct = 6'(randBits(6));
      if (opcode == `OP_R) begin
        // Bit 4 moves any listed funct onto an unused code
        if (funct == `FN_ADD || funct == `FN_SUB || funct == `FN_AND ||
            funct == `FN_SLT || funct == `FN_JR || funct == `FN_XCHG) begin
          funct = funct ^ 6'b010000;
        end
      end else if (opcode == `OP_ADDI || opcode == `OP_J || opcode == `OP_JAL) begin
        opcode = opcode ^ 6'b110000;
      end
    end else begin
      pick = 6'(randBits(4) % 9);
      funct = 6'(randBits(6));
      case (pick)
        0: {opcode, funct} = {`OP_R, `FN_ADD};
        1: {opcode, funct} = {`OP_R, `FN_SUB};
        2: {opcode, funct} = {`OP_R, `FN_AND};
        3: {opcode, funct} = {`OP_R, `FN_SLT};
        4: {opcode, funct} = {`OP_R, `FN_JR};
        5: {opcode, funct} = {`OP_XCHG_R, `FN_XCHG};
        6: opcode = `OP_ADDI;
        7: opcode = `OP_J;
        default: opcode = `OP_JAL;
      endcase
    end
    instrCount++;
  endtask

  initial begin
    logic seen;
    lfsr = Seed;
    instrCount = 0;
    timeoutCount = 0;
    reset = 1'b1;
    opcode = `OP_R;
    funct = `FN_ADD;
    overflow = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    while (instrCount < NumInstr && timeoutCount == 0) begin
      waitForIrLoad(seen);
      if (!seen) begin
        $display("Timed out after %0d cycles waiting for the IR load word", IrTimeout);
        timeoutCount++;
      end else begin
        driveInstruction();
      end
    end
    // Let the last instruction run through execute
    if (timeoutCount == 0) begin
      waitForIrLoad(seen);
      if (!seen) begin
        $display("Timed out waiting for the fetch after the last instruction");
        timeoutCount++;
      end
    end
    $display("Instructions: %0d, exceptions: %0d, checks: %0d, errors: %0d, timeouts: %0d",
             instrCount, monitor.exceptCount, monitor.checkCount, monitor.errorCount,
             timeoutCount);
    if (monitor.errorCount == 0 && timeoutCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
